// ==== common/decode_ctrl_if.sv ====
`timescale 1ns/100ps

interface decode_ctrl_if;
   import decode_pkg::*;

   alu_op_e             alu_op;
   logic                alu_src;
   logic                mem_read;
   logic                mem_write;
   mem_size_e           mem_size;
   logic                reg_write;
   logic                branch;
   logic                jal;
   logic                jalr;
   logic                lui;
   logic                auipc;
   logic [imm_w-1:0]    imm;
   logic [reg_aw-1:0]   rd;
   logic                illegal;

   // Decoder side
   modport source (
      output alu_op, alu_src, mem_read, mem_write, mem_size, reg_write,
             branch, jal, jalr, lui, auipc, imm, rd, illegal
   );

   // Forwarding, branch and pipeline register side
   modport sink (
      input alu_op, alu_src, mem_read, mem_write, mem_size, reg_write,
            branch, jal, jalr, lui, auipc, imm, rd, illegal
   );

endinterface

// ==== common/decode_pkg.sv ====
package decode_pkg;

   ////////////////////////////////////////////////////
   // Widths
   ////////////////////////////////////////////////////
   localparam int xlen   = 32;
   localparam int reg_aw = 5;
   localparam int pc_w   = 16;
   localparam int imm_w  = 32;

   ////////////////////////////////////////////////////
   // RV32I major opcodes
   ////////////////////////////////////////////////////
   typedef enum logic [6:0] {
      op_lui    = 7'b0110111,
      op_auipc  = 7'b0010111,
      op_jal    = 7'b1101111,
      op_jalr   = 7'b1100111,
      op_branch = 7'b1100011,
      op_load   = 7'b0000011,
      op_store  = 7'b0100011,
      op_imm    = 7'b0010011,
      op_reg    = 7'b0110011
   } opcode_e;

   // ALU operations for the execute stage
   typedef enum logic [3:0] {
      alu_add  = 4'd0,
      alu_sub  = 4'd1,
      alu_sll  = 4'd2,
      alu_slt  = 4'd3,
      alu_sltu = 4'd4,
      alu_xor  = 4'd5,
      alu_srl  = 4'd6,
      alu_sra  = 4'd7,
      alu_or   = 4'd8,
      alu_and  = 4'd9
   } alu_op_e;

   // Same encoding as funct3 of loads and stores
   typedef enum logic [2:0] {
      mem_b  = 3'b000,
      mem_h  = 3'b001,
      mem_w  = 3'b010,
      mem_bu = 3'b100,
      mem_hu = 3'b101
   } mem_size_e;

   // ADDI x0,x0,0
   localparam logic [31:0] nop_ins = 32'h0000_0013;

endpackage

// ==== decode/branch_resolve.sv ====
`timescale 1ns/100ps

module branch_resolve (
   input  logic [decode_pkg::xlen-1:0] rs1_fwd,
   input  logic [decode_pkg::xlen-1:0] rs2_fwd,
   input  logic [decode_pkg::pc_w-1:0] pres_addr,
   input  logic                        hz,
   input  logic                        squash,
   decode_ctrl_if.sink                 ctrl,
   input  logic [2:0]                  funct3,
   output logic                        branch_taken,
   output logic [decode_pkg::pc_w-1:0] branch_target
);
   import decode_pkg::*;

   logic             cond;
   logic [xlen-1:0]  base;
   logic [xlen-1:0]  sum;

   // Branch condition from funct3
   always_comb begin
      case (funct3)
         3'b000:  cond = (rs1_fwd == rs2_fwd);
         3'b001:  cond = (rs1_fwd != rs2_fwd);
         3'b100:  cond = ($signed(rs1_fwd) < $signed(rs2_fwd));
         3'b101:  cond = ($signed(rs1_fwd) >= $signed(rs2_fwd));
         3'b110:  cond = (rs1_fwd < rs2_fwd);
         3'b111:  cond = (rs1_fwd >= rs2_fwd);
         default: cond = 1'b0;
      endcase
   end

   // No redirect on stale operands or from a squashed slot
   assign branch_taken = !hz && !squash &&
                         (ctrl.jal || ctrl.jalr || (ctrl.branch && cond));

   ////////////////////////////////////////////////////
   // Target
   ////////////////////////////////////////////////////
   assign base = ctrl.jalr ? rs1_fwd : xlen'(pres_addr);
   assign sum  = base + ctrl.imm;

   // JALR clears bit 0
   assign branch_target = {sum[pc_w-1:1], sum[0] & ~ctrl.jalr};

endmodule

// ==== decode/id_ex_reg.sv ====
`timescale 1ns/100ps

module id_ex_reg (
   input  logic                          bus,
   input  logic                          rst_n,
   input  logic                          stall,
   input  logic                          hz,
   input  logic                          branch_taken,
   input  logic [decode_pkg::pc_w-1:0]   pres_addr,
   input  logic [decode_pkg::reg_aw-1:0] rs1_addr,
   input  logic [decode_pkg::reg_aw-1:0] rs2_addr,
   input  logic [decode_pkg::xlen-1:0]   dout_rs1,
   input  logic [decode_pkg::xlen-1:0]   dout_rs2,
   decode_ctrl_if.sink                   ctrl,
   output logic                          squash,
   output decode_pkg::alu_op_e           id_ex_alu_op,
   output logic                          id_ex_alu_src,
   output logic                          id_ex_mem_read,
   output logic                          id_ex_mem_write,
   output decode_pkg::mem_size_e         id_ex_mem_size,
   output logic                          id_ex_reg_write,
   output logic                          id_ex_jal,
   output logic                          id_ex_jalr,
   output logic                          id_ex_lui,
   output logic                          id_ex_auipc,
   output logic                          id_ex_illegal,
   output logic [decode_pkg::imm_w-1:0]  id_ex_imm,
   output logic [decode_pkg::reg_aw-1:0] id_ex_rs1,
   output logic [decode_pkg::reg_aw-1:0] id_ex_rs2,
   output logic [decode_pkg::reg_aw-1:0] id_ex_rd,
   output logic [decode_pkg::xlen-1:0]   id_ex_dout_rs1,
   output logic [decode_pkg::xlen-1:0]   id_ex_dout_rs2,
   output logic [decode_pkg::pc_w-1:0]   id_ex_pres_addr
);
   import decode_pkg::*;

   logic bubble;

   assign bubble = hz || squash;

   always_ff @(posedge bus or negedge rst_n) begin
      if (!rst_n) begin
         squash          <= 1'b0;
         id_ex_alu_op    <= alu_add;
         id_ex_alu_src   <= 1'b0;
         id_ex_mem_read  <= 1'b0;
         id_ex_mem_write <= 1'b0;
         id_ex_mem_size  <= mem_b;
         id_ex_reg_write <= 1'b0;
         id_ex_jal       <= 1'b0;
         id_ex_jalr      <= 1'b0;
         id_ex_lui       <= 1'b0;
         id_ex_auipc     <= 1'b0;
         id_ex_illegal   <= 1'b0;
         id_ex_imm       <= '0;
         id_ex_rs1       <= '0;
         id_ex_rs2       <= '0;
         id_ex_rd        <= '0;
         id_ex_dout_rs1  <= '0;
         id_ex_dout_rs2  <= '0;
         id_ex_pres_addr <= '0;
      end else if (!stall) begin
         // Only the slot right after a redirect is killed
         squash          <= branch_taken;
         id_ex_pres_addr <= pres_addr;
         if (bubble) begin
            // Fields of the NOP, control bits all off
            id_ex_alu_op    <= alu_add;
            id_ex_alu_src   <= 1'b0;
            id_ex_mem_read  <= 1'b0;
            id_ex_mem_write <= 1'b0;
            id_ex_mem_size  <= mem_b;
            id_ex_reg_write <= 1'b0;
            id_ex_jal       <= 1'b0;
            id_ex_jalr      <= 1'b0;
            id_ex_lui       <= 1'b0;
            id_ex_auipc     <= 1'b0;
            id_ex_illegal   <= 1'b0;
            id_ex_imm       <= {{20{nop_ins[31]}}, nop_ins[31:20]};
            id_ex_rs1       <= nop_ins[19:15];
            id_ex_rs2       <= '0;
            id_ex_rd        <= nop_ins[11:7];
            id_ex_dout_rs1  <= '0;
            id_ex_dout_rs2  <= '0;
         end else begin
            id_ex_alu_op    <= ctrl.alu_op;
            id_ex_alu_src   <= ctrl.alu_src;
            id_ex_mem_read  <= ctrl.mem_read;
            id_ex_mem_write <= ctrl.mem_write;
            id_ex_mem_size  <= ctrl.mem_size;
            id_ex_reg_write <= ctrl.reg_write;
            id_ex_jal       <= ctrl.jal;
            id_ex_jalr      <= ctrl.jalr;
            id_ex_lui       <= ctrl.lui;
            id_ex_auipc     <= ctrl.auipc;
            id_ex_illegal   <= ctrl.illegal;
            id_ex_imm       <= ctrl.imm;
            id_ex_rs1       <= rs1_addr;
            id_ex_rs2       <= rs2_addr;
            id_ex_rd        <= ctrl.rd;
            id_ex_dout_rs1  <= dout_rs1;
            id_ex_dout_rs2  <= dout_rs2;
         end
      end
   end

   ////////////////////////////////////////////////////
   // Checks
   ////////////////////////////////////////////////////
   a_bubble_no_write: assert property (@(posedge bus) disable iff (!rst_n)
      !stall && bubble |=> !id_ex_reg_write && !id_ex_mem_write);

   a_stall_hold: assert property (@(posedge bus) disable iff (!rst_n)
      stall |=> $stable({id_ex_alu_op, id_ex_alu_src, id_ex_mem_read, id_ex_mem_write,
                         id_ex_mem_size, id_ex_reg_write, id_ex_jal, id_ex_jalr,
                         id_ex_lui, id_ex_auipc, id_ex_illegal, id_ex_imm, id_ex_rs1,
                         id_ex_rs2, id_ex_rd, id_ex_dout_rs1, id_ex_dout_rs2,
                         id_ex_pres_addr}));

endmodule

// ==== decode/instr_control.sv ====
`timescale 1ns/100ps

module instr_control (
   input  logic [31:0]          ins,
   decode_ctrl_if.source        ctrl
);
   import decode_pkg::*;

   logic [2:0]       funct3;
   logic             alt;
   logic [imm_w-1:0] i_imm, s_imm, b_imm, u_imm, j_imm;

   assign funct3 = ins[14:12];
   // funct7 bit 5 selects SUB and SRA
   assign alt    = ins[30];

   ////////////////////////////////////////////////////
   // Immediate formats
   ////////////////////////////////////////////////////
   assign i_imm = {{20{ins[31]}}, ins[31:20]};
   assign s_imm = {{20{ins[31]}}, ins[31:25], ins[11:7]};
   assign b_imm = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
   assign u_imm = {ins[31:12], 12'b0};
   assign j_imm = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};

   function automatic alu_op_e alu_decode(input logic [2:0] f3, input logic sub_ok);
      case (f3)
         3'b000:  return sub_ok ? alu_sub : alu_add;
         3'b001:  return alu_sll;
         3'b010:  return alu_slt;
         3'b011:  return alu_sltu;
         3'b100:  return alu_xor;
         3'b101:  return alt ? alu_sra : alu_srl;
         3'b110:  return alu_or;
         default: return alu_and;
      endcase
   endfunction

   ////////////////////////////////////////////////////
   // Control decode
   ////////////////////////////////////////////////////
   always_comb begin
      ctrl.alu_op    = alu_add;
      ctrl.alu_src   = 1'b1;
      ctrl.mem_read  = 1'b0;
      ctrl.mem_write = 1'b0;
      ctrl.mem_size  = mem_w;
      ctrl.reg_write = 1'b1;
      ctrl.branch    = 1'b0;
      ctrl.jal       = 1'b0;
      ctrl.jalr      = 1'b0;
      ctrl.lui       = 1'b0;
      ctrl.auipc     = 1'b0;
      ctrl.imm       = i_imm;
      ctrl.illegal   = 1'b0;
      case (opcode_e'(ins[6:0]))
         op_lui: begin
            ctrl.lui = 1'b1;
            ctrl.imm = u_imm;
         end
         op_auipc: begin
            ctrl.auipc = 1'b1;
            ctrl.imm   = u_imm;
         end
         op_jal: begin
            ctrl.jal = 1'b1;
            ctrl.imm = j_imm;
         end
         op_jalr: ctrl.jalr = 1'b1;
         op_branch: begin
            // Compare happens here in decode and EX only sees a subtract
            ctrl.branch    = 1'b1;
            ctrl.alu_op    = alu_sub;
            ctrl.alu_src   = 1'b0;
            ctrl.reg_write = 1'b0;
            ctrl.imm       = b_imm;
         end
         op_load: begin
            ctrl.mem_read = 1'b1;
            ctrl.mem_size = mem_size_e'(funct3);
         end
         op_store: begin
            ctrl.mem_write = 1'b1;
            ctrl.reg_write = 1'b0;
            ctrl.mem_size  = mem_size_e'(funct3);
            ctrl.imm       = s_imm;
         end
         op_imm: ctrl.alu_op = alu_decode(funct3, 1'b0);
         op_reg: begin
            ctrl.alu_op  = alu_decode(funct3, alt);
            ctrl.alu_src = 1'b0;
         end
         default: begin
            ctrl.illegal   = 1'b1;
            ctrl.alu_src   = 1'b0;
            ctrl.reg_write = 1'b0;
         end
      endcase
   end

   // Stores and branches carry no destination
   assign ctrl.rd = ctrl.reg_write ? ins[11:7] : '0;

endmodule

// ==== decode/operand_forward.sv ====
`timescale 1ns/100ps

module operand_forward (
   input  logic [decode_pkg::reg_aw-1:0] rs1_addr,
   input  logic [decode_pkg::reg_aw-1:0] rs2_addr,
   input  logic [decode_pkg::xlen-1:0]   dout_rs1,
   input  logic [decode_pkg::xlen-1:0]   dout_rs2,
   input  logic                          ex_mem_regwrite,
   input  logic                          ex_mem_memread,
   input  logic [decode_pkg::reg_aw-1:0] ex_mem_rd,
   input  logic [decode_pkg::xlen-1:0]   ex_mem_alures,
   input  logic                          mem_wb_regwrite,
   input  logic [decode_pkg::reg_aw-1:0] mem_wb_rd,
   input  logic [decode_pkg::xlen-1:0]   wb_res,
   input  logic                          id_ex_memread,
   input  logic                          id_ex_regwrite,
   input  logic [decode_pkg::reg_aw-1:0] id_ex_rd,
   decode_ctrl_if.sink                   ctrl,
   output logic [decode_pkg::xlen-1:0]   rs1_fwd,
   output logic [decode_pkg::xlen-1:0]   rs2_fwd,
   output logic                          hz
);
   import decode_pkg::*;

   logic use_rs1, use_rs2;
   logic compare;

   // Which source registers the instruction really reads
   assign use_rs1 = !(ctrl.lui || ctrl.auipc || ctrl.jal || ctrl.illegal);
   assign use_rs2 = ctrl.mem_write || (!ctrl.alu_src && !ctrl.illegal);
   assign compare = ctrl.branch || ctrl.jalr;

   // Non-zero destination that matches a source in use
   function automatic logic reads_reg(input logic [reg_aw-1:0] rd);
      return (rd != '0) && ((use_rs1 && rd == rs1_addr) || (use_rs2 && rd == rs2_addr));
   endfunction

   // Youngest producer wins, loads in EX/MEM are not ready yet
   function automatic logic [xlen-1:0] fwd_sel(input logic [reg_aw-1:0] rs,
                                               input logic [xlen-1:0]   rf_val);
      if (ex_mem_regwrite && !ex_mem_memread && ex_mem_rd != '0 && ex_mem_rd == rs)
         return ex_mem_alures;
      if (mem_wb_regwrite && mem_wb_rd != '0 && mem_wb_rd == rs)
         return wb_res;
      return rf_val;
   endfunction

   always_comb begin
      rs1_fwd = fwd_sel(rs1_addr, dout_rs1);
      rs2_fwd = fwd_sel(rs2_addr, dout_rs2);
   end

   ////////////////////////////////////////////////////
   // Hazard detection
   ////////////////////////////////////////////////////
   always_comb begin
      hz = 1'b0;
      // Load-use against ID/EX
      if (id_ex_memread && reads_reg(id_ex_rd))
         hz = 1'b1;
      // Compare in decode needs the value before EX produces it
      if (compare && id_ex_regwrite && reads_reg(id_ex_rd))
         hz = 1'b1;
      if (compare && ex_mem_memread && reads_reg(ex_mem_rd))
         hz = 1'b1;
   end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -j 0 --top-module tb_decode_stage -f verilog.f &&
./obj_dir/Vtb_decode_stage | tee /dev/stderr | grep -qx "STATUS: PASS" &&
echo "decode stage simulation passed" ||
{ echo "decode stage simulation failed"; exit 1; }

// ==== src/decode_stage.sv ====
`timescale 1ns/100ps

module decode_stage (
   input  logic                          bus,
   input  logic                          rst_n,
   input  logic [31:0]                   ins,
   input  logic [decode_pkg::pc_w-1:0]   pres_addr,
   input  logic [decode_pkg::xlen-1:0]   dout_rs1,
   input  logic [decode_pkg::xlen-1:0]   dout_rs2,
   input  logic                          ex_mem_regwrite,
   input  logic                          ex_mem_memread,
   input  logic [decode_pkg::reg_aw-1:0] ex_mem_rd,
   input  logic [decode_pkg::xlen-1:0]   ex_mem_alures,
   input  logic                          mem_wb_regwrite,
   input  logic [decode_pkg::reg_aw-1:0] mem_wb_rd,
   input  logic [decode_pkg::xlen-1:0]   wb_res,
   input  logic                          stall,
   output logic [decode_pkg::reg_aw-1:0] rs1_addr,
   output logic [decode_pkg::reg_aw-1:0] rs2_addr,
   output logic                          hz,
   output logic                          branch_taken,
   output logic [decode_pkg::pc_w-1:0]   branch_target,
   output decode_pkg::alu_op_e           id_ex_alu_op,
   output logic                          id_ex_alu_src,
   output logic                          id_ex_mem_read,
   output logic                          id_ex_mem_write,
   output decode_pkg::mem_size_e         id_ex_mem_size,
   output logic                          id_ex_reg_write,
   output logic                          id_ex_jal,
   output logic                          id_ex_jalr,
   output logic                          id_ex_lui,
   output logic                          id_ex_auipc,
   output logic                          id_ex_illegal,
   output logic [decode_pkg::imm_w-1:0]  id_ex_imm,
   output logic [decode_pkg::reg_aw-1:0] id_ex_rs1,
   output logic [decode_pkg::reg_aw-1:0] id_ex_rs2,
   output logic [decode_pkg::reg_aw-1:0] id_ex_rd,
   output logic [decode_pkg::xlen-1:0]   id_ex_dout_rs1,
   output logic [decode_pkg::xlen-1:0]   id_ex_dout_rs2,
   output logic [decode_pkg::pc_w-1:0]   id_ex_pres_addr
);
   import decode_pkg::*;

   logic [xlen-1:0] rs1_fwd, rs2_fwd;
   logic            squash;

   // Register file read addresses
   assign rs1_addr = ins[19:15];
   assign rs2_addr = ins[24:20];

   decode_ctrl_if ctrl ();

   instr_control u_ctrl (.ins(ins), .ctrl(ctrl.source));

   operand_forward u_fwd (
      .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
      .dout_rs1(dout_rs1), .dout_rs2(dout_rs2),
      .ex_mem_regwrite(ex_mem_regwrite), .ex_mem_memread(ex_mem_memread),
      .ex_mem_rd(ex_mem_rd), .ex_mem_alures(ex_mem_alures),
      .mem_wb_regwrite(mem_wb_regwrite), .mem_wb_rd(mem_wb_rd), .wb_res(wb_res),
      .id_ex_memread(id_ex_mem_read), .id_ex_regwrite(id_ex_reg_write),
      .id_ex_rd(id_ex_rd), .ctrl(ctrl.sink),
      .rs1_fwd(rs1_fwd), .rs2_fwd(rs2_fwd), .hz(hz)
   );

   branch_resolve u_br (
      .rs1_fwd(rs1_fwd), .rs2_fwd(rs2_fwd), .pres_addr(pres_addr),
      .hz(hz), .squash(squash), .ctrl(ctrl.sink), .funct3(ins[14:12]),
      .branch_taken(branch_taken), .branch_target(branch_target)
   );

   id_ex_reg u_id_ex (
      .bus(bus), .rst_n(rst_n), .stall(stall), .hz(hz), .branch_taken(branch_taken),
      .pres_addr(pres_addr), .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
      .dout_rs1(dout_rs1), .dout_rs2(dout_rs2), .ctrl(ctrl.sink), .squash(squash),
      .id_ex_alu_op(id_ex_alu_op), .id_ex_alu_src(id_ex_alu_src),
      .id_ex_mem_read(id_ex_mem_read), .id_ex_mem_write(id_ex_mem_write),
      .id_ex_mem_size(id_ex_mem_size), .id_ex_reg_write(id_ex_reg_write),
      .id_ex_jal(id_ex_jal), .id_ex_jalr(id_ex_jalr), .id_ex_lui(id_ex_lui),
      .id_ex_auipc(id_ex_auipc), .id_ex_illegal(id_ex_illegal), .id_ex_imm(id_ex_imm),
      .id_ex_rs1(id_ex_rs1), .id_ex_rs2(id_ex_rs2), .id_ex_rd(id_ex_rd),
      .id_ex_dout_rs1(id_ex_dout_rs1), .id_ex_dout_rs2(id_ex_dout_rs2),
      .id_ex_pres_addr(id_ex_pres_addr)
   );

endmodule

// ==== testbench/tb_decode_stage.sv ====
`timescale 1ns/100ps

module tb_decode_stage;
   import decode_pkg::*;

   localparam int n_rand  = 120;
   localparam int n_lu    = 20;
   localparam int n_br    = 60;
   localparam int n_jmp   = 20;
   localparam int n_stall = 5;
   localparam int n_ill   = 30;
   localparam int total_cycles = 8 + n_rand + 3 * n_lu + 2 * n_br + 3 * n_jmp
                                 + 6 * n_stall + n_ill;

   // Expected ID/EX contents plus the combinational results
   typedef struct packed {
      alu_op_e           alu_op;
      logic              alu_src, mem_read, mem_write, reg_write;
      logic              jal, jalr, lui, auipc, illegal;
      mem_size_e         mem_size;
      logic [imm_w-1:0]  imm;
      logic [reg_aw-1:0] rs1, rs2, rd;
      logic [xlen-1:0]   d1, d2;
      logic [pc_w-1:0]   pc;
      logic              xfer, hz, taken;
      logic [pc_w-1:0]   target;
   } dec_t;

   logic                bus, rst_n, stall;
   logic [31:0]         ins;
   logic [pc_w-1:0]     pres_addr;
   logic [xlen-1:0]     dout_rs1, dout_rs2, ex_mem_alures, wb_res;
   logic                ex_mem_regwrite, ex_mem_memread, mem_wb_regwrite;
   logic [reg_aw-1:0]   ex_mem_rd, mem_wb_rd;
   logic [reg_aw-1:0]   rs1_addr, rs2_addr;
   logic                hz, branch_taken;
   logic [pc_w-1:0]     branch_target;
   alu_op_e             id_ex_alu_op;
   mem_size_e           id_ex_mem_size;
   logic                id_ex_alu_src, id_ex_mem_read, id_ex_mem_write, id_ex_reg_write;
   logic                id_ex_jal, id_ex_jalr, id_ex_lui, id_ex_auipc, id_ex_illegal;
   logic [imm_w-1:0]    id_ex_imm;
   logic [reg_aw-1:0]   id_ex_rs1, id_ex_rs2, id_ex_rd;
   logic [xlen-1:0]     id_ex_dout_rs1, id_ex_dout_rs2;
   logic [pc_w-1:0]     id_ex_pres_addr;

   dec_t model;
   logic m_squash;
   int   n_err;
   int   n_chk;

   decode_stage dut (.*);

   initial begin
      bus = 1'b0;
      forever #4 bus = ~bus;
   end

   //////////////////////////////////////////////////
   // Reference model
   //////////////////////////////////////////////////
   function automatic alu_op_e alu_for(input logic [2:0] f3, input logic sub, input logic arith);
      case (f3)
         3'd0:    return sub ? alu_sub : alu_add;
         3'd1:    return alu_sll;
         3'd2:    return alu_slt;
         3'd3:    return alu_sltu;
         3'd4:    return alu_xor;
         3'd5:    return arith ? alu_sra : alu_srl;
         3'd6:    return alu_or;
         default: return alu_and;
      endcase
   endfunction

   function automatic logic reads_reg(input logic [31:0] i, input logic use1, input logic use2,
                                      input logic [reg_aw-1:0] r);
      return r != 5'd0 && ((use1 && r == i[19:15]) || (use2 && r == i[24:20]));
   endfunction

   // EX/MEM result beats MEM/WB unless EX/MEM holds a load
   function automatic logic [xlen-1:0] forwarded(input logic [reg_aw-1:0] rs,
                                                 input logic [xlen-1:0] rf);
      logic ex_hit;
      logic wb_hit;
      ex_hit = ex_mem_regwrite && !ex_mem_memread && ex_mem_rd == rs && rs != 5'd0;
      wb_hit = mem_wb_regwrite && mem_wb_rd == rs && rs != 5'd0;
      return ex_hit ? ex_mem_alures : (wb_hit ? wb_res : rf);
   endfunction

   function automatic dec_t bubble_fields(input logic [pc_w-1:0] pc);
      dec_t d;
      d = '0;
      d.alu_op = alu_add;
      d.mem_size = mem_b;
      d.pc = pc;
      return d;
   endfunction

   function automatic dec_t decode_model(input logic [31:0] i, input dec_t prev, input logic sq);
      dec_t d;
      logic [2:0] f3;
      logic br, use1, use2, cmp, cond;
      logic [xlen-1:0] a, b, sum;
      d = '0;
      f3 = i[14:12];
      br = 1'b0;
      d.alu_op = alu_add;
      d.alu_src = 1'b1;
      d.reg_write = 1'b1;
      d.mem_size = mem_w;
      d.imm = {{20{i[31]}}, i[31:20]};
      case (opcode_e'(i[6:0]))
         op_lui: begin
            d.lui = 1'b1;
            d.imm = {i[31:12], 12'h000};
         end
         op_auipc: begin
            d.auipc = 1'b1;
            d.imm = {i[31:12], 12'h000};
         end
         op_jal: begin
            d.jal = 1'b1;
            d.imm = {{12{i[31]}}, i[19:12], i[20], i[30:21], 1'b0};
         end
         op_jalr: d.jalr = 1'b1;
         op_branch: begin
            br = 1'b1;
            d.alu_op = alu_sub;
            d.alu_src = 1'b0;
            d.reg_write = 1'b0;
            d.imm = {{20{i[31]}}, i[7], i[30:25], i[11:8], 1'b0};
         end
         op_load: begin
            d.mem_read = 1'b1;
            d.mem_size = mem_size_e'(f3);
         end
         op_store: begin
            d.mem_write = 1'b1;
            d.reg_write = 1'b0;
            d.mem_size = mem_size_e'(f3);
            d.imm = {{20{i[31]}}, i[31:25], i[11:7]};
         end
         op_imm: d.alu_op = alu_for(f3, 1'b0, i[30]);
         op_reg: begin
            d.alu_op = alu_for(f3, i[30], i[30]);
            d.alu_src = 1'b0;
         end
         default: begin
            d.illegal = 1'b1;
            d.alu_src = 1'b0;
            d.reg_write = 1'b0;
         end
      endcase
      d.rs1 = i[19:15];
      d.rs2 = i[24:20];
      d.rd = d.reg_write ? i[11:7] : 5'd0;
      d.d1 = dout_rs1;
      d.d2 = dout_rs2;
      d.pc = pres_addr;

      // Hazards against ID/EX and EX/MEM
      use1 = !(d.lui || d.auipc || d.jal || d.illegal);
      use2 = br || d.mem_write || i[6:0] == op_reg;
      cmp = br || d.jalr;
      d.hz = (prev.mem_read && reads_reg(i, use1, use2, prev.rd))
             || (cmp && prev.reg_write && reads_reg(i, use1, use2, prev.rd))
             || (cmp && ex_mem_memread && reads_reg(i, use1, use2, ex_mem_rd));

      a = forwarded(d.rs1, dout_rs1);
      b = forwarded(d.rs2, dout_rs2);
      case (f3)
         3'd0:    cond = a == b;
         3'd1:    cond = a != b;
         3'd4:    cond = $signed(a) < $signed(b);
         3'd5:    cond = $signed(a) >= $signed(b);
         3'd6:    cond = a < b;
         3'd7:    cond = a >= b;
         default: cond = 1'b0;
      endcase
      d.xfer = br || d.jal || d.jalr;
      d.taken = !d.hz && !sq && (d.jal || d.jalr || (br && cond));
      // JALR jumps to an even address off rs1
      if (d.jalr)
         sum = (a + d.imm) & ~32'd1;
      else
         sum = 32'(pres_addr) + d.imm;
      d.target = sum[pc_w-1:0];
      return d;
   endfunction

   //////////////////////////////////////////////////
   // Compare tasks
   //////////////////////////////////////////////////
   task automatic report(input string name, input logic [31:0] got, input logic [31:0] want);
      n_err++;
      $display("[FAIL] %0t ns %s got 0x%0h expected 0x%0h", $time, name, got, want);
   endtask

   task automatic alu_check(input string name, input alu_op_e got, input alu_op_e want);
      n_chk++;
      if (got !== want)
         report(name, 32'(got), 32'(want));
   endtask

   task automatic size_check(input string name, input mem_size_e got, input mem_size_e want);
      n_chk++;
      if (got !== want)
         report(name, 32'(got), 32'(want));
   endtask

   task automatic word_check(input string name, input logic [31:0] got, input logic [31:0] want);
      n_chk++;
      if (got !== want)
         report(name, got, want);
   endtask

   task automatic addr_check(input string name, input logic [pc_w-1:0] got,
                             input logic [pc_w-1:0] want);
      n_chk++;
      if (got !== want)
         report(name, 32'(got), 32'(want));
   endtask

   task automatic bit_check(input string name, input logic got, input logic want);
      n_chk++;
      if (got !== want)
         report(name, 32'(got), 32'(want));
   endtask

   task automatic compare_id_ex();
      alu_check("id_ex_alu_op", id_ex_alu_op, model.alu_op);
      size_check("id_ex_mem_size", id_ex_mem_size, model.mem_size);
      bit_check("id_ex_alu_src", id_ex_alu_src, model.alu_src);
      bit_check("id_ex_mem_read", id_ex_mem_read, model.mem_read);
      bit_check("id_ex_mem_write", id_ex_mem_write, model.mem_write);
      bit_check("id_ex_reg_write", id_ex_reg_write, model.reg_write);
      bit_check("id_ex_jal", id_ex_jal, model.jal);
      bit_check("id_ex_jalr", id_ex_jalr, model.jalr);
      bit_check("id_ex_lui", id_ex_lui, model.lui);
      bit_check("id_ex_auipc", id_ex_auipc, model.auipc);
      bit_check("id_ex_illegal", id_ex_illegal, model.illegal);
      word_check("id_ex_imm", id_ex_imm, model.imm);
      word_check("id_ex_rs1", 32'(id_ex_rs1), 32'(model.rs1));
      word_check("id_ex_rs2", 32'(id_ex_rs2), 32'(model.rs2));
      word_check("id_ex_rd", 32'(id_ex_rd), 32'(model.rd));
      word_check("id_ex_dout_rs1", id_ex_dout_rs1, model.d1);
      word_check("id_ex_dout_rs2", id_ex_dout_rs2, model.d2);
      addr_check("id_ex_pres_addr", id_ex_pres_addr, model.pc);
   endtask

   // Combinational results 1 ns before the edge and registers 2 ns after it
   initial begin : model_check
      dec_t cur;
      @(posedge rst_n);
      // Reset contents of ID/EX
      compare_id_ex();
      forever begin
         #3;
         cur = decode_model(ins, model, m_squash);
         word_check("rs1_addr", 32'(rs1_addr), 32'(cur.rs1));
         word_check("rs2_addr", 32'(rs2_addr), 32'(cur.rs2));
         bit_check("hz", hz, cur.hz);
         bit_check("branch_taken", branch_taken, cur.taken);
         if (cur.xfer)
            addr_check("branch_target", branch_target, cur.target);
         if (!stall) begin
            if (cur.hz || m_squash)
               model = bubble_fields(pres_addr);
            else
               model = cur;
            m_squash = cur.taken;
         end
         @(posedge bus);
         #2;
         compare_id_ex();
         @(negedge bus);
      end
   end

   //////////////////////////////////////////////////
   // Stimulus
   //////////////////////////////////////////////////
   function automatic logic [31:0] random_ins(input int kind);
      logic [31:0] i;
      logic [2:0]  f3;
      i  = $urandom;
      f3 = 3'($urandom_range(0, 4));
      case (kind)
         0: i[6:0] = op_reg;
         1: i[6:0] = op_imm;
         2: begin
            i[6:0] = op_load;
            // Size code 3'b011 is not a load
            i[14:12] = (f3 > 3'd2) ? f3 + 3'd1 : f3;
         end
         3: begin
            i[6:0] = op_store;
            i[14:12] = 3'($urandom_range(0, 2));
         end
         4: i[6:0] = op_lui;
         default: i[6:0] = op_auipc;
      endcase
      return i;
   endfunction

   function automatic logic known_op(input logic [6:0] op);
      case (op)
         op_lui, op_auipc, op_jal, op_jalr, op_branch, op_load, op_store, op_imm, op_reg:
            return 1'b1;
         default: return 1'b0;
      endcase
   endfunction

   // Few distinct values so equal and signed cases come up often
   function automatic logic [31:0] operand_val();
      case ($urandom_range(0, 3))
         0: return 32'h0000_0000;
         1: return 32'h0000_0001;
         2: return 32'hffff_ffff;
         default: return 32'h8000_0000;
      endcase
   endfunction

   task automatic present(input logic [31:0] i);
      @(negedge bus);
      ins       = i;
      pres_addr = pres_addr + 16'd4;
      dout_rs1  = $urandom;
      dout_rs2  = $urandom;
   endtask

   initial begin : stim
      logic [31:0]       r;
      logic [2:0]        f3;
      logic [reg_aw-1:0] rd;
      r = $urandom(32'h77bf_4fd4);
      rst_n = 1'b0;
      stall = 1'b0;
      ins = nop_ins;
      pres_addr = '0;
      dout_rs1 = '0;
      dout_rs2 = '0;
      ex_mem_regwrite = 1'b0;
      ex_mem_memread = 1'b0;
      ex_mem_rd = '0;
      ex_mem_alures = '0;
      mem_wb_regwrite = 1'b0;
      mem_wb_rd = '0;
      wb_res = '0;
      model = bubble_fields('0);
      m_squash = 1'b0;
      n_err = 0;
      n_chk = 0;
      repeat (2) @(posedge bus);
      @(negedge bus);
      rst_n = 1'b1;

      // Plain decode of every non-control format
      repeat (n_rand) present(random_ins(int'($urandom_range(0, 5))));

      // Load followed by a user, then the user again after the bubble
      repeat (n_lu) begin
         rd = 5'($urandom_range(1, 31));
         r = random_ins(2);
         r[11:7] = rd;
         present(r);
         r = random_ins(0);
         if ($urandom_range(0, 1) == 1)
            r[19:15] = rd;
         else
            r[24:20] = rd;
         present(r);
         present(r);
      end

      // Branches with operands from EX/MEM, MEM/WB or the register file
      repeat (n_br) begin
         present(nop_ins);
         r = random_ins(0);
         r[6:0] = op_branch;
         f3 = 3'($urandom_range(0, 5));
         r[14:12] = (f3 > 3'd1) ? f3 + 3'd2 : f3;
         present(r);
         dout_rs1 = operand_val();
         dout_rs2 = operand_val();
         ex_mem_regwrite = 1'($urandom_range(0, 1));
         ex_mem_memread = ($urandom_range(0, 7) == 0);
         ex_mem_rd = ($urandom_range(0, 1) == 1) ? r[19:15] : r[24:20];
         ex_mem_alures = operand_val();
         mem_wb_regwrite = 1'($urandom_range(0, 1));
         mem_wb_rd = ($urandom_range(0, 1) == 1) ? r[19:15] : r[24:20];
         wb_res = operand_val();
      end
      ex_mem_regwrite = 1'b0;
      ex_mem_memread = 1'b0;
      mem_wb_regwrite = 1'b0;

      // Jumps and the squashed slot behind each one
      repeat (n_jmp) begin
         present(nop_ins);
         r = $urandom;
         r[6:0] = ($urandom_range(0, 1) == 1) ? op_jal : op_jalr;
         present(r);
         // A jump in the squashed slot must not redirect
         r = random_ins(0);
         if ($urandom_range(0, 3) == 0)
            r[6:0] = op_jal;
         present(r);
      end

      // ID/EX frozen while inputs keep moving
      repeat (n_stall) begin
         present(random_ins(int'($urandom_range(0, 5))));
         repeat (4) begin
            present(random_ins(int'($urandom_range(0, 5))));
            stall = 1'b1;
            ex_mem_alures = $urandom;
            wb_res = $urandom;
         end
         present(random_ins(int'($urandom_range(0, 5))));
         stall = 1'b0;
      end

      // Opcodes outside RV32I base set
      repeat (n_ill) begin
         r = $urandom;
         while (known_op(r[6:0]))
            r[6:0] = 7'($urandom);
         present(r);
      end

      present(nop_ins);
      present(nop_ins);
      @(negedge bus);
      $display("%0d checks, %0d mismatches", n_chk, n_err);
      if (n_err == 0)
         $display("STATUS: PASS");
      else
         $display("STATUS: FAIL");
      $finish;
   end

   initial begin : watchdog
      #(total_cycles * 8 + 200);
      $display("Watchdog expired before the stimulus finished");
      $display("STATUS: FAIL");
      $finish;
   end

endmodule

// ==== verilog.f ====
common/decode_pkg.sv
common/decode_ctrl_if.sv
decode/instr_control.sv
decode/operand_forward.sv
decode/branch_resolve.sv
decode/id_ex_reg.sv
src/decode_stage.sv
testbench/tb_decode_stage.sv
